// File: rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

   localparam int unsigned XLEN = 32;

   typedef logic [XLEN-1:0] xlen_t;
   typedef logic [4:0]      reg_addr_t;

   // Major opcodes from instr[6:2]
   typedef enum logic [4:0] {
      OPCODE_LOAD     = 5'b00000,
      OPCODE_MISC_MEM = 5'b00011,
      OPCODE_OP_IMM   = 5'b00100,
      OPCODE_AUIPC    = 5'b00101,
      OPCODE_STORE    = 5'b01000,
      OPCODE_OP       = 5'b01100,
      OPCODE_LUI      = 5'b01101,
      OPCODE_BRANCH   = 5'b11000,
      OPCODE_JALR     = 5'b11001,
      OPCODE_JAL      = 5'b11011,
      OPCODE_SYSTEM   = 5'b11100
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_I_OPS_NONE, ALU_I_OPS_ADD, ALU_I_OPS_SUB, ALU_I_OPS_SLL,
      ALU_I_OPS_SLT, ALU_I_OPS_SLTU, ALU_I_OPS_XOR, ALU_I_OPS_SRL,
      ALU_I_OPS_SRA, ALU_I_OPS_OR, ALU_I_OPS_AND, ALU_I_OPS_COPY_OPR2
   } alu_i_ops_e;

   typedef enum logic [3:0] {
      ALU_M_OPS_NONE, ALU_M_OPS_MUL, ALU_M_OPS_MULH, ALU_M_OPS_MULHSU,
      ALU_M_OPS_MULHU, ALU_M_OPS_DIV, ALU_M_OPS_DIVU, ALU_M_OPS_REM,
      ALU_M_OPS_REMU
   } alu_m_ops_e;

   typedef enum logic [2:0] {
      LD_OPS_NONE, LD_OPS_LB, LD_OPS_LH, LD_OPS_LW, LD_OPS_LBU, LD_OPS_LHU
   } ld_ops_e;

   typedef enum logic [1:0] {ST_OPS_NONE, ST_OPS_SB, ST_OPS_SH, ST_OPS_SW} st_ops_e;

   typedef enum logic [2:0] {
      BR_OPS_NONE, BR_OPS_EQ, BR_OPS_NE, BR_OPS_LT, BR_OPS_GE, BR_OPS_LTU, BR_OPS_GEU
   } br_ops_e;

   typedef enum logic [1:0] {
      CSR_OPS_NONE, CSR_OPS_WRITE, CSR_OPS_SET, CSR_OPS_CLEAR
   } csr_ops_e;

   typedef enum logic {SYS_OPS_NONE, SYS_OPS_MRET} sys_ops_e;

   typedef enum logic {ALU_OPR1_PC, ALU_OPR1_REG} opr1_sel_e;
   typedef enum logic {ALU_OPR2_IMM, ALU_OPR2_REG} opr2_sel_e;
   typedef enum logic {ALU_CMP_OPR2_REG, ALU_CMP_OPR2_IMM} cmp_opr2_sel_e;
   typedef enum logic {CSR_OPR_REG, CSR_OPR_IMM} csr_opr_sel_e;

   typedef enum logic [2:0] {
      RD_WRB_NONE, RD_WRB_ALU, RD_WRB_M_ALU, RD_WRB_DMEM, RD_WRB_INC_PC, RD_WRB_CSR
   } rd_wrb_sel_e;

   // Standard mcause codes
   typedef enum logic [3:0] {
      EXC_CODE_NO_EXCEPTION      = 4'd0,
      EXC_CODE_INSTR_ACCESS_FAULT = 4'd1,
      EXC_CODE_ILLEGAL_INSTR     = 4'd2,
      EXC_CODE_BREAKPOINT        = 4'd3,
      EXC_CODE_ECALL_MMODE       = 4'd11
   } exc_code_e;

   typedef enum logic [2:0] {
      IMM_FMT_I, IMM_FMT_SHAMT, IMM_FMT_S, IMM_FMT_B, IMM_FMT_U, IMM_FMT_J
   } imm_fmt_e;

   typedef struct packed {
      xlen_t instr;
      xlen_t pc;
      xlen_t pc_next;
   } if2id_data_s;

   typedef struct packed {
      logic      exc_req;
      exc_code_e exc_code;
   } if2id_ctrl_s;

   typedef struct packed {
      xlen_t imm;
      xlen_t rs1_data;
      xlen_t rs2_data;
      xlen_t instr;
      xlen_t pc;
      xlen_t pc_next;
   } id2exe_data_s;

   typedef struct packed {
      alu_i_ops_e    alu_i_ops;
      alu_m_ops_e    alu_m_ops;
      ld_ops_e       ld_ops;
      st_ops_e       st_ops;
      br_ops_e       branch_ops;
      csr_ops_e      csr_ops;
      sys_ops_e      sys_ops;
      opr1_sel_e     alu_opr1_sel;
      opr2_sel_e     alu_opr2_sel;
      cmp_opr2_sel_e alu_cmp_opr2_sel;
      csr_opr_sel_e  csr_opr_sel;
      rd_wrb_sel_e   rd_wrb_sel;
      logic          exc_req;
      exc_code_e     exc_code;
      logic          rd_wr_req;
      logic          jump_req;
      logic          branch_req;
      logic          fence_i_req;
   } id2exe_ctrl_s;

   typedef struct packed {
      logic      rd_wr_req;
      reg_addr_t rd_addr;
      xlen_t     rd_data;
   } wrb2id_fb_s;

   localparam id2exe_ctrl_s ID2EXE_CTRL_IDLE = '{
      alu_i_ops:        ALU_I_OPS_NONE,
      alu_m_ops:        ALU_M_OPS_NONE,
      ld_ops:           LD_OPS_NONE,
      st_ops:           ST_OPS_NONE,
      branch_ops:       BR_OPS_NONE,
      csr_ops:          CSR_OPS_NONE,
      sys_ops:          SYS_OPS_NONE,
      alu_opr1_sel:     ALU_OPR1_PC,
      alu_opr2_sel:     ALU_OPR2_IMM,
      alu_cmp_opr2_sel: ALU_CMP_OPR2_REG,
      csr_opr_sel:      CSR_OPR_REG,
      rd_wrb_sel:       RD_WRB_NONE,
      exc_req:          1'b0,
      exc_code:         EXC_CODE_NO_EXCEPTION,
      rd_wr_req:        1'b0,
      jump_req:         1'b0,
      branch_req:       1'b0,
      fence_i_req:      1'b0
   };

endpackage : decode_pkg

`default_nettype wire

// File: rtl/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import decode_pkg::*; (
   input  xlen_t        instr_i,
   output logic         hit_o,
   output logic         illegal_o,
   output id2exe_ctrl_s ctrl_o,
   output imm_fmt_e     imm_fmt_o
);

   rv_opcode_e opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = rv_opcode_e'(instr_i[6:2]);
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   always_comb begin
      ctrl_o    = ID2EXE_CTRL_IDLE;
      hit_o     = 1'b1;
      illegal_o = 1'b0;
      imm_fmt_o = IMM_FMT_I;
      case (opcode)
         OPCODE_OP: begin
            ctrl_o.rd_wr_req        = 1'b1;
            ctrl_o.rd_wrb_sel       = RD_WRB_ALU;
            ctrl_o.alu_opr1_sel     = ALU_OPR1_REG;
            ctrl_o.alu_opr2_sel     = ALU_OPR2_REG;
            ctrl_o.alu_cmp_opr2_sel = ALU_CMP_OPR2_REG;
            case (funct7)
               7'b0000000: begin
                  case (funct3)
                     3'b000: ctrl_o.alu_i_ops = ALU_I_OPS_ADD;
                     3'b001: ctrl_o.alu_i_ops = ALU_I_OPS_SLL;
                     3'b010: ctrl_o.alu_i_ops = ALU_I_OPS_SLT;
                     3'b011: ctrl_o.alu_i_ops = ALU_I_OPS_SLTU;
                     3'b100: ctrl_o.alu_i_ops = ALU_I_OPS_XOR;
                     3'b101: ctrl_o.alu_i_ops = ALU_I_OPS_SRL;
                     3'b110: ctrl_o.alu_i_ops = ALU_I_OPS_OR;
                     default: ctrl_o.alu_i_ops = ALU_I_OPS_AND;
                  endcase
               end
               7'b0100000: begin
                  case (funct3)
                     3'b000: ctrl_o.alu_i_ops = ALU_I_OPS_SUB;
                     3'b101: ctrl_o.alu_i_ops = ALU_I_OPS_SRA;
                     default: illegal_o = 1'b1;
                  endcase
               end
               7'b0000001: begin
                  ctrl_o.rd_wrb_sel = RD_WRB_M_ALU;  // Result from mul/div unit
                  ctrl_o.alu_m_ops  = alu_m_ops_e'({1'b0, funct3} + 4'd1);  // MUL..REMU in order
               end
               default: illegal_o = 1'b1;
            endcase
         end
         OPCODE_OP_IMM: begin
            ctrl_o.rd_wr_req        = 1'b1;
            ctrl_o.rd_wrb_sel       = RD_WRB_ALU;
            ctrl_o.alu_opr1_sel     = ALU_OPR1_REG;
            ctrl_o.alu_opr2_sel     = ALU_OPR2_IMM;
            ctrl_o.alu_cmp_opr2_sel = ALU_CMP_OPR2_IMM;  // SLTI/SLTIU compare against imm
            case (funct3)
               3'b000: ctrl_o.alu_i_ops = ALU_I_OPS_ADD;
               3'b010: ctrl_o.alu_i_ops = ALU_I_OPS_SLT;
               3'b011: ctrl_o.alu_i_ops = ALU_I_OPS_SLTU;
               3'b100: ctrl_o.alu_i_ops = ALU_I_OPS_XOR;
               3'b110: ctrl_o.alu_i_ops = ALU_I_OPS_OR;
               3'b111: ctrl_o.alu_i_ops = ALU_I_OPS_AND;
               3'b001: begin
                  ctrl_o.alu_i_ops = ALU_I_OPS_SLL;
                  imm_fmt_o        = IMM_FMT_SHAMT;
               end
               default: begin
                  imm_fmt_o = IMM_FMT_SHAMT;
                  case (funct7)
                     7'b0000000: ctrl_o.alu_i_ops = ALU_I_OPS_SRL;
                     7'b0100000: ctrl_o.alu_i_ops = ALU_I_OPS_SRA;
                     default:    illegal_o = 1'b1;
                  endcase
               end
            endcase
         end
         OPCODE_LUI: begin
            ctrl_o.rd_wr_req  = 1'b1;
            ctrl_o.rd_wrb_sel = RD_WRB_ALU;
            ctrl_o.alu_i_ops  = ALU_I_OPS_COPY_OPR2;  // rd = upper imm
            imm_fmt_o         = IMM_FMT_U;
         end
         OPCODE_AUIPC: begin
            ctrl_o.rd_wr_req  = 1'b1;
            ctrl_o.rd_wrb_sel = RD_WRB_ALU;
            ctrl_o.alu_i_ops  = ALU_I_OPS_ADD;  // PC + upper imm
            imm_fmt_o         = IMM_FMT_U;
         end
         default: hit_o = 1'b0;
      endcase
   end

endmodule : alu_decoder

`default_nettype wire

// File: rtl/flow_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module flow_decoder import decode_pkg::*; (
   input  xlen_t        instr_i,
   output logic         hit_o,
   output logic         illegal_o,
   output id2exe_ctrl_s ctrl_o,
   output imm_fmt_e     imm_fmt_o
);

   rv_opcode_e opcode;
   logic [2:0] funct3;

   assign opcode = rv_opcode_e'(instr_i[6:2]);
   assign funct3 = instr_i[14:12];

   always_comb begin
      ctrl_o    = ID2EXE_CTRL_IDLE;
      hit_o     = 1'b1;
      illegal_o = 1'b0;
      imm_fmt_o = IMM_FMT_I;
      case (opcode)
         OPCODE_LOAD: begin
            ctrl_o.rd_wr_req    = 1'b1;
            ctrl_o.rd_wrb_sel   = RD_WRB_DMEM;
            ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            ctrl_o.alu_i_ops    = ALU_I_OPS_ADD;  // Address is rs1 + imm
            case (funct3)
               3'b000: ctrl_o.ld_ops = LD_OPS_LB;
               3'b001: ctrl_o.ld_ops = LD_OPS_LH;
               3'b010: ctrl_o.ld_ops = LD_OPS_LW;
               3'b100: ctrl_o.ld_ops = LD_OPS_LBU;
               3'b101: ctrl_o.ld_ops = LD_OPS_LHU;
               default: illegal_o = 1'b1;
            endcase
         end
         OPCODE_STORE: begin
            ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            ctrl_o.alu_i_ops    = ALU_I_OPS_ADD;
            imm_fmt_o           = IMM_FMT_S;
            case (funct3)
               3'b000: ctrl_o.st_ops = ST_OPS_SB;
               3'b001: ctrl_o.st_ops = ST_OPS_SH;
               3'b010: ctrl_o.st_ops = ST_OPS_SW;
               default: illegal_o = 1'b1;
            endcase
         end
         OPCODE_BRANCH: begin
            ctrl_o.alu_i_ops  = ALU_I_OPS_ADD;  // Target is PC + offset
            ctrl_o.branch_req = 1'b1;
            imm_fmt_o         = IMM_FMT_B;
            case (funct3)
               3'b000: ctrl_o.branch_ops = BR_OPS_EQ;
               3'b001: ctrl_o.branch_ops = BR_OPS_NE;
               3'b100: ctrl_o.branch_ops = BR_OPS_LT;
               3'b101: ctrl_o.branch_ops = BR_OPS_GE;
               3'b110: ctrl_o.branch_ops = BR_OPS_LTU;
               3'b111: ctrl_o.branch_ops = BR_OPS_GEU;
               default: illegal_o = 1'b1;
            endcase
         end
         OPCODE_JAL, OPCODE_JALR: begin
            ctrl_o.rd_wr_req  = 1'b1;
            ctrl_o.rd_wrb_sel = RD_WRB_INC_PC;  // Link address
            ctrl_o.alu_i_ops  = ALU_I_OPS_ADD;
            ctrl_o.jump_req   = 1'b1;
            if (opcode == OPCODE_JALR) begin
               ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            end else begin
               imm_fmt_o = IMM_FMT_J;
            end
         end
         OPCODE_MISC_MEM: begin
            case (funct3)
               3'b000: ctrl_o.fence_i_req = 1'b0;  // FENCE acts as a NOP here
               3'b001: ctrl_o.fence_i_req = 1'b1;  // FENCE.I flushes the pipe
               default: illegal_o = 1'b1;
            endcase
         end
         default: hit_o = 1'b0;
      endcase
   end

endmodule : flow_decoder

`default_nettype wire

// File: rtl/sys_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sys_decoder import decode_pkg::*; (
   input  xlen_t        instr_i,
   output logic         hit_o,
   output logic         illegal_o,
   output id2exe_ctrl_s ctrl_o,
   output imm_fmt_e     imm_fmt_o
);

   logic [2:0] funct3;
   logic [6:0] funct7;
   logic [4:0] funct5;

   assign funct3    = instr_i[14:12];
   assign funct7    = instr_i[31:25];
   assign funct5    = instr_i[24:20];
   assign hit_o     = (rv_opcode_e'(instr_i[6:2]) == OPCODE_SYSTEM);
   assign imm_fmt_o = IMM_FMT_I;  // CSR address lives in the I field

   always_comb begin
      ctrl_o    = ID2EXE_CTRL_IDLE;
      illegal_o = 1'b0;
      case (funct3)
         3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111: begin
            ctrl_o.rd_wr_req  = 1'b1;
            ctrl_o.rd_wrb_sel = RD_WRB_CSR;  // rd gets the old CSR value
            ctrl_o.csr_ops    = csr_ops_e'(funct3[1:0]);  // 1/2/3 map to WRITE/SET/CLEAR
            if (funct3[2]) begin
               ctrl_o.csr_opr_sel = CSR_OPR_IMM;  // uimm from rs1 field
            end else begin
               ctrl_o.csr_opr_sel  = CSR_OPR_REG;
               ctrl_o.alu_opr1_sel = ALU_OPR1_REG;
            end
         end
         3'b000: begin
            if (funct7 == 7'b0000000 && funct5 == 5'b00000) begin
               ctrl_o.exc_req  = 1'b1;  // ECALL
               ctrl_o.exc_code = EXC_CODE_ECALL_MMODE;
            end else if (funct7 == 7'b0000000 && funct5 == 5'b00001) begin
               ctrl_o.exc_req  = 1'b1;  // EBREAK
               ctrl_o.exc_code = EXC_CODE_BREAKPOINT;
            end else if (funct7 == 7'b0011000) begin
               ctrl_o.sys_ops = SYS_OPS_MRET;
            end else begin
               illegal_o = 1'b1;
            end
         end
         default: illegal_o = 1'b1;
      endcase
   end

endmodule : sys_decoder

`default_nettype wire

// File: rtl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import decode_pkg::*; (
   input  xlen_t    instr_i,
   input  imm_fmt_e imm_fmt_i,
   output xlen_t    imm_o
);

   logic sign;

   assign sign = instr_i[31];

   always_comb begin
      case (imm_fmt_i)
         IMM_FMT_SHAMT: begin
            imm_o = {27'b0, instr_i[24:20]};  // Shift amount, zero extended
         end
         IMM_FMT_S: begin
            imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
         end
         IMM_FMT_B: begin
            imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
         end
         IMM_FMT_U: begin
            imm_o = {instr_i[31:12], 12'b0};
         end
         IMM_FMT_J: begin
            imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
         end
         default: begin
            imm_o = {{21{sign}}, instr_i[30:20]};  // I format
         end
      endcase
   end

endmodule : imm_gen

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import decode_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  reg_addr_t  rs1_addr_i,
   input  reg_addr_t  rs2_addr_i,
   output xlen_t      rs1_data_o,
   output xlen_t      rs2_data_o,
   input  wrb2id_fb_s wr_fb_i
);

   xlen_t regs [1:31];  // x0 has no storage
   logic  wr_en;

   assign wr_en = wr_fb_i.rd_wr_req && (wr_fb_i.rd_addr != '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_fb_i.rd_addr] <= wr_fb_i.rd_data;
      end
   end

   // Reads see the array directly, so a same-cycle write shows up a cycle later
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule : reg_file

`default_nettype wire

// File: rtl/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import decode_pkg::*; (
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  if2id_data_s  if2id_data_i,
   input  if2id_ctrl_s  if2id_ctrl_i,
   input  wrb2id_fb_s   wrb2id_fb_i,
   output id2exe_data_s id2exe_data_o,
   output id2exe_ctrl_s id2exe_ctrl_o
);

   xlen_t        instr;
   xlen_t        imm;
   xlen_t        rs1_data;
   xlen_t        rs2_data;
   logic         alu_hit, flow_hit, sys_hit;
   logic         alu_illegal, flow_illegal, sys_illegal;
   id2exe_ctrl_s alu_ctrl, flow_ctrl, sys_ctrl;
   imm_fmt_e     alu_fmt, flow_fmt, sys_fmt;
   id2exe_ctrl_s dec_ctrl;
   imm_fmt_e     dec_fmt;
   logic         dec_illegal;

   assign instr = if2id_data_i.instr;

   alu_decoder  alu_dec  (.instr_i(instr), .hit_o(alu_hit), .illegal_o(alu_illegal),
                          .ctrl_o(alu_ctrl), .imm_fmt_o(alu_fmt));
   flow_decoder flow_dec (.instr_i(instr), .hit_o(flow_hit), .illegal_o(flow_illegal),
                          .ctrl_o(flow_ctrl), .imm_fmt_o(flow_fmt));
   sys_decoder  sys_dec  (.instr_i(instr), .hit_o(sys_hit), .illegal_o(sys_illegal),
                          .ctrl_o(sys_ctrl), .imm_fmt_o(sys_fmt));

   // At most one decoder claims a given opcode
   always_comb begin
      dec_ctrl    = ID2EXE_CTRL_IDLE;
      dec_fmt     = IMM_FMT_I;
      dec_illegal = 1'b1;  // Unknown opcode
      if (alu_hit) begin
         dec_ctrl    = alu_ctrl;
         dec_fmt     = alu_fmt;
         dec_illegal = alu_illegal;
      end else if (flow_hit) begin
         dec_ctrl    = flow_ctrl;
         dec_fmt     = flow_fmt;
         dec_illegal = flow_illegal;
      end else if (sys_hit) begin
         dec_ctrl    = sys_ctrl;
         dec_fmt     = sys_fmt;
         dec_illegal = sys_illegal;
      end
   end

   always_comb begin
      id2exe_ctrl_o = dec_ctrl;
      if (if2id_ctrl_i.exc_req) begin
         id2exe_ctrl_o          = ID2EXE_CTRL_IDLE;  // Fetch fault beats decoding
         id2exe_ctrl_o.exc_req  = 1'b1;
         id2exe_ctrl_o.exc_code = if2id_ctrl_i.exc_code;
      end else if (dec_illegal) begin
         id2exe_ctrl_o          = ID2EXE_CTRL_IDLE;
         id2exe_ctrl_o.exc_req  = 1'b1;
         id2exe_ctrl_o.exc_code = EXC_CODE_ILLEGAL_INSTR;
      end
   end

   imm_gen imm_gen0 (.instr_i(instr), .imm_fmt_i(dec_fmt), .imm_o(imm));

   reg_file rf0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rs1_addr_i (instr[19:15]),
      .rs2_addr_i (instr[24:20]),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wr_fb_i    (wrb2id_fb_i)
   );

   assign id2exe_data_o = '{imm: imm, rs1_data: rs1_data, rs2_data: rs2_data,
                            instr: instr, pc: if2id_data_i.pc,
                            pc_next: if2id_data_i.pc_next};

endmodule : decode

`default_nettype wire

// File: verification/tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode import decode_pkg::*; ();

   localparam wrb2id_fb_s NO_WRITE = '0;

   logic         clk_i;
   logic         rst_n_i;
   if2id_data_s  if2id_data_i;
   if2id_ctrl_s  if2id_ctrl_i;
   wrb2id_fb_s   wrb2id_fb_i;
   id2exe_data_s id2exe_data_o;
   id2exe_ctrl_s id2exe_ctrl_o;

   xlen_t        shadow [0:31];  // Expected register contents
   id2exe_ctrl_s exp_ctrl;
   id2exe_data_s exp_data;
   logic         checking;
   logic         pending;       // A driven word has not been checked yet

   decode dut0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .if2id_data_i(if2id_data_i),
                .if2id_ctrl_i(if2id_ctrl_i), .wrb2id_fb_i(wrb2id_fb_i),
                .id2exe_data_o(id2exe_data_o), .id2exe_ctrl_o(id2exe_ctrl_o));

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic alu_i_ops_e base_op(input logic [2:0] f3, input logic alt);
      case (f3)
         3'd0: return alt ? ALU_I_OPS_SUB : ALU_I_OPS_ADD;
         3'd1: return ALU_I_OPS_SLL;
         3'd2: return ALU_I_OPS_SLT;
         3'd3: return ALU_I_OPS_SLTU;
         3'd4: return ALU_I_OPS_XOR;
         3'd5: return alt ? ALU_I_OPS_SRA : ALU_I_OPS_SRL;
         3'd6: return ALU_I_OPS_OR;
         default: return ALU_I_OPS_AND;
      endcase
   endfunction

   function automatic alu_m_ops_e m_op(input logic [2:0] f3);
      case (f3)
         3'd0: return ALU_M_OPS_MUL;
         3'd1: return ALU_M_OPS_MULH;
         3'd2: return ALU_M_OPS_MULHSU;
         3'd3: return ALU_M_OPS_MULHU;
         3'd4: return ALU_M_OPS_DIV;
         3'd5: return ALU_M_OPS_DIVU;
         3'd6: return ALU_M_OPS_REM;
         default: return ALU_M_OPS_REMU;
      endcase
   endfunction

   // Reference decode of one word, fetch fault and illegal overrides included
   function automatic id2exe_ctrl_s model_ctrl(input xlen_t instr, input if2id_ctrl_s fetch);
      id2exe_ctrl_s c;
      logic         ill;
      logic [2:0]   f3;
      logic [6:0]   f7;
      c   = ID2EXE_CTRL_IDLE;
      ill = 1'b0;
      f3  = instr[14:12];
      f7  = instr[31:25];
      case (instr[6:2])
         OPCODE_OP: begin
            c.rd_wr_req    = 1'b1;
            c.rd_wrb_sel   = RD_WRB_ALU;
            c.alu_opr1_sel = ALU_OPR1_REG;
            c.alu_opr2_sel = ALU_OPR2_REG;
            if (f7 == 7'h01) begin
               c.rd_wrb_sel = RD_WRB_M_ALU;
               c.alu_m_ops  = m_op(f3);
            end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
               c.alu_i_ops = base_op(f3, f7[5]);
            end else begin
               ill = 1'b1;
            end
         end
         OPCODE_OP_IMM: begin
            c.rd_wr_req        = 1'b1;
            c.rd_wrb_sel       = RD_WRB_ALU;
            c.alu_opr1_sel     = ALU_OPR1_REG;
            c.alu_cmp_opr2_sel = ALU_CMP_OPR2_IMM;
            c.alu_i_ops        = base_op(f3, f3 == 3'd5 && f7[5]);
            ill = (f3 == 3'd5) && (f7 != 7'h00) && (f7 != 7'h20);
         end
         OPCODE_LUI, OPCODE_AUIPC: begin
            c.rd_wr_req  = 1'b1;
            c.rd_wrb_sel = RD_WRB_ALU;
            c.alu_i_ops  = instr[5] ? ALU_I_OPS_COPY_OPR2 : ALU_I_OPS_ADD;  // Bit 5 set for LUI
         end
         OPCODE_LOAD: begin
            c.rd_wr_req    = 1'b1;
            c.rd_wrb_sel   = RD_WRB_DMEM;
            c.alu_opr1_sel = ALU_OPR1_REG;
            c.alu_i_ops    = ALU_I_OPS_ADD;
            case (f3)
               3'd0: c.ld_ops = LD_OPS_LB;
               3'd1: c.ld_ops = LD_OPS_LH;
               3'd2: c.ld_ops = LD_OPS_LW;
               3'd4: c.ld_ops = LD_OPS_LBU;
               3'd5: c.ld_ops = LD_OPS_LHU;
               default: ill = 1'b1;
            endcase
         end
         OPCODE_STORE: begin
            c.alu_opr1_sel = ALU_OPR1_REG;
            c.alu_i_ops    = ALU_I_OPS_ADD;
            case (f3)
               3'd0: c.st_ops = ST_OPS_SB;
               3'd1: c.st_ops = ST_OPS_SH;
               3'd2: c.st_ops = ST_OPS_SW;
               default: ill = 1'b1;
            endcase
         end
         OPCODE_BRANCH: begin
            c.alu_i_ops  = ALU_I_OPS_ADD;
            c.branch_req = 1'b1;
            case (f3)
               3'd0: c.branch_ops = BR_OPS_EQ;
               3'd1: c.branch_ops = BR_OPS_NE;
               3'd4: c.branch_ops = BR_OPS_LT;
               3'd5: c.branch_ops = BR_OPS_GE;
               3'd6: c.branch_ops = BR_OPS_LTU;
               3'd7: c.branch_ops = BR_OPS_GEU;
               default: ill = 1'b1;
            endcase
         end
         OPCODE_JAL, OPCODE_JALR: begin
            c.rd_wr_req  = 1'b1;
            c.rd_wrb_sel = RD_WRB_INC_PC;
            c.alu_i_ops  = ALU_I_OPS_ADD;
            c.jump_req   = 1'b1;
            if (instr[6:2] == OPCODE_JALR) begin
               c.alu_opr1_sel = ALU_OPR1_REG;
            end
         end
         OPCODE_MISC_MEM: begin
            c.fence_i_req = (f3 == 3'd1);
            ill = (f3 > 3'd1);
         end
         OPCODE_SYSTEM: begin
            if (f3 == 3'd0) begin
               if (f7 == 7'h00 && instr[24:20] == 5'd0) begin
                  c.exc_req  = 1'b1;
                  c.exc_code = EXC_CODE_ECALL_MMODE;
               end else if (f7 == 7'h00 && instr[24:20] == 5'd1) begin
                  c.exc_req  = 1'b1;
                  c.exc_code = EXC_CODE_BREAKPOINT;
               end else if (f7 == 7'h18) begin
                  c.sys_ops = SYS_OPS_MRET;
               end else begin
                  ill = 1'b1;
               end
            end else if (f3 == 3'd4) begin
               ill = 1'b1;
            end else begin
               c.rd_wr_req  = 1'b1;
               c.rd_wrb_sel = RD_WRB_CSR;
               case (f3[1:0])
                  2'd1: c.csr_ops = CSR_OPS_WRITE;
                  2'd2: c.csr_ops = CSR_OPS_SET;
                  default: c.csr_ops = CSR_OPS_CLEAR;
               endcase
               if (f3[2]) begin
                  c.csr_opr_sel = CSR_OPR_IMM;
               end else begin
                  c.alu_opr1_sel = ALU_OPR1_REG;
               end
            end
         end
         default: ill = 1'b1;
      endcase
      if (fetch.exc_req || ill) begin
         c          = ID2EXE_CTRL_IDLE;
         c.exc_req  = 1'b1;
         c.exc_code = fetch.exc_req ? fetch.exc_code : EXC_CODE_ILLEGAL_INSTR;
      end
      return c;
   endfunction

   // Format follows the opcode even for reserved funct3 values
   function automatic xlen_t model_imm(input xlen_t instr);
      logic [2:0] f3;
      f3 = instr[14:12];
      case (instr[6:2])
         OPCODE_OP_IMM: begin
            if (f3 == 3'd1 || f3 == 3'd5) return {27'd0, instr[24:20]};
            return {{20{instr[31]}}, instr[31:20]};
         end
         OPCODE_STORE:  return {{20{instr[31]}}, instr[31:25], instr[11:7]};
         OPCODE_BRANCH: return {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
         OPCODE_LUI, OPCODE_AUIPC: return {instr[31:12], 12'd0};
         OPCODE_JAL:    return {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
         default:       return {{20{instr[31]}}, instr[31:20]};
      endcase
   endfunction

   function automatic xlen_t add_word(input reg_addr_t a, input reg_addr_t b);
      return {7'd0, b, a, 3'd0, 5'd1, 7'b0110011};  // add x1, a, b
   endfunction

   task automatic report_mismatch(input string name, input logic [191:0] got,
                                  input logic [191:0] exp);
      $display("[FAIL] t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1);
   endtask

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
         end
      end else if (wrb2id_fb_i.rd_wr_req && wrb2id_fb_i.rd_addr != 5'd0) begin
         shadow[wrb2id_fb_i.rd_addr] = wrb2id_fb_i.rd_data;
      end
   end

   always @(negedge clk_i) begin
      if (checking) begin
         exp_ctrl = model_ctrl(if2id_data_i.instr, if2id_ctrl_i);
         exp_data = '{imm: model_imm(if2id_data_i.instr),
                      rs1_data: shadow[if2id_data_i.instr[19:15]],
                      rs2_data: shadow[if2id_data_i.instr[24:20]],
                      instr: if2id_data_i.instr, pc: if2id_data_i.pc,
                      pc_next: if2id_data_i.pc_next};
         assert (id2exe_ctrl_o === exp_ctrl)
            else report_mismatch("id2exe_ctrl_o", id2exe_ctrl_o, exp_ctrl);
         assert (id2exe_data_o === exp_data)
            else report_mismatch("id2exe_data_o", id2exe_data_o, exp_data);
         pending = 1'b0;
      end
   end

   task automatic drive(input xlen_t instr, input logic fault, input wrb2id_fb_s fb);
      xlen_t pc;
      @(posedge clk_i);
      #1;
      pc                     = $urandom & ~32'h3;
      if2id_data_i           = '{instr: instr, pc: pc, pc_next: pc + 32'd4};
      if2id_ctrl_i.exc_req   = fault;
      if2id_ctrl_i.exc_code  = fault ? EXC_CODE_INSTR_ACCESS_FAULT : EXC_CODE_NO_EXCEPTION;
      wrb2id_fb_i            = fb;
      pending                = 1'b1;
   endtask

   task automatic decode_word(input xlen_t instr);
      drive(instr, 1'b0, NO_WRITE);
   endtask

   task automatic apply_reset();
      rst_n_i = 1'b0;
      repeat (4) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
   endtask

   task automatic read_all_regs();
      for (int r = 0; r < 32; r++) begin
         decode_word(add_word(5'(r), 5'(31 - r)));
      end
   endtask

   // Every funct3 with a handful of funct7 values, other fields random
   task automatic sweep_opcode(input logic [4:0] op);
      logic [6:0] f7_set [5];
      xlen_t      w;
      f7_set = '{7'h00, 7'h20, 7'h01, 7'h18, 7'h00};
      for (int f3 = 0; f3 < 8; f3++) begin
         for (int j = 0; j < 5; j++) begin
            w         = $urandom;
            w[31:25]  = (j == 4) ? 7'($urandom) : f7_set[j];
            w[14:12]  = 3'(f3);
            w[6:0]    = {op, 2'b11};
            decode_word(w);
         end
      end
   endtask

   initial begin
      wrb2id_fb_s fb;
      reg_addr_t  last_addr;
      int         t;
      void'($urandom(32'h3678));
      rst_n_i      = 1'b0;
      if2id_data_i = '0;
      if2id_ctrl_i = '0;
      wrb2id_fb_i  = '0;
      checking     = 1'b0;
      pending      = 1'b0;
      last_addr    = '0;
      apply_reset();
      checking = 1'b1;
      read_all_regs();
      for (int k = 0; k < 64; k++) begin
         fb = '{rd_wr_req: 1'b1, rd_addr: 5'($urandom), rd_data: $urandom};
         if (k % 8 == 0) fb.rd_addr = 5'd0;  // x0 stays zero
         drive(add_word(last_addr, fb.rd_addr), 1'b0, fb);  // rs2 shows the old value
         last_addr = fb.rd_addr;
      end
      decode_word(add_word(last_addr, last_addr));
      apply_reset();
      read_all_regs();
      decode_word(32'h00000013);
      for (int op = 0; op < 32; op++) begin
         sweep_opcode(5'(op));
      end
      decode_word(32'h00000073);  // ECALL
      decode_word(32'h00100073);  // EBREAK
      decode_word(32'h30200073);  // MRET
      decode_word(32'h00200073);
      decode_word(32'h10500073);
      for (int k = 0; k < 24; k++) begin
         drive($urandom, 1'b1, NO_WRITE);
      end
      for (t = 0; t < 8 && pending; t++) begin
         @(posedge clk_i);
      end
      if (pending) begin
         $display("Timeout: the last decoded word was never checked");
         $display("Verification failed");
         $fatal(1);
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule : tb_decode

`default_nettype wire

// File: files.f
rtl/decode_pkg.sv
rtl/alu_decoder.sv
rtl/flow_decoder.sv
rtl/sys_decoder.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/decode.sv
verification/tb_decode.sv
